// File: filelist.f
logic/periph_pkg.sv
logic/periph_reg_if.sv
logic/periph_reg_decoder.sv
logic/periph_timer.sv
logic/periph_irq_ctrl.sv
logic/periph_subsys.sv
verif/periph_tb.sv

// File: logic/periph_irq_ctrl.sv
// ------------------------------------------------
// Interrupt controller
// Latches timer expiries as pending and raises one
// level interrupt gated by enable, priority and
// threshold. A claim read hands out the best ID
// ------------------------------------------------
`default_nettype none

module periph_irq_ctrl
    import periph_pkg::*;
#(
    parameter int NUM_TIMERS = 4
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    periph_reg_if.client          bus_i,
    input  logic [NUM_TIMERS-1:0] expire_i,
    output logic                  irq_o
);

    irq_addr_t             addr;
    logic [PRIO_W-1:0]     prio_q [NUM_TIMERS];
    logic [NUM_TIMERS-1:0] enable_q;
    logic [NUM_TIMERS-1:0] pending_q;
    logic [PRIO_W-1:0]     thresh_q;
    logic                  irq_q;
    logic [NUM_TIMERS-1:0] eligible;
    logic [NUM_TIMERS-1:0] clear_mask;
    logic [ID_W-1:0]       claim_id;
    logic [PRIO_W-1:0]     best_prio;
    logic                  wr_en;
    logic                  claim_rd;

    assign addr     = bus_i.addr.irq;
    assign wr_en    = bus_i.sel && bus_i.we;
    assign claim_rd = bus_i.sel && !bus_i.we && (addr.kind == IRQ_CLAIM);

    // ------------------------------------------------
    // Eligibility and claim arbitration
    // ------------------------------------------------
    // Strict compare keeps the lowest ID on a tie
    always_comb begin
        claim_id  = '0;
        best_prio = '0;
        for (int i = 0; i < NUM_TIMERS; i++) begin
            eligible[i] = pending_q[i] && enable_q[i] && (prio_q[i] > thresh_q);
            if (eligible[i] && (prio_q[i] > best_prio)) begin
                claim_id  = ID_W'(i + 1);
                best_prio = prio_q[i];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_TIMERS; i++) begin
            clear_mask[i] = claim_rd && (claim_id == ID_W'(i + 1));
        end
    end

    // ------------------------------------------------
    // State
    // ------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_TIMERS; i++) begin
                prio_q[i] <= '0;
            end
            enable_q  <= '0;
            pending_q <= '0;
            thresh_q  <= '0;
            irq_q     <= 1'b0;
        end else begin
            // New expiry wins over a claim of the same source
            pending_q <= (pending_q & ~clear_mask) | expire_i;
            irq_q     <= |eligible;

            if (wr_en) begin
                case (addr.kind)
                    IRQ_PRIO: begin
                        for (int i = 0; i < NUM_TIMERS; i++) begin
                            if (int'(addr.src) == i) begin
                                prio_q[i] <= bus_i.wdata[PRIO_W-1:0];
                            end
                        end
                    end
                    IRQ_ENABLE: enable_q <= bus_i.wdata[NUM_TIMERS-1:0];
                    IRQ_THRESH: thresh_q <= bus_i.wdata[PRIO_W-1:0];
                    default: ;
                endcase
            end
        end
    end

    assign irq_o = irq_q;

    // ------------------------------------------------
    // Read data
    // ------------------------------------------------
    always_comb begin
        bus_i.rdata = '0;
        case (addr.kind)
            IRQ_PRIO: begin
                for (int i = 0; i < NUM_TIMERS; i++) begin
                    if (int'(addr.src) == i) begin
                        bus_i.rdata = DATA_W'(prio_q[i]);
                    end
                end
            end
            IRQ_PENDING: bus_i.rdata = DATA_W'(pending_q);
            IRQ_ENABLE:  bus_i.rdata = DATA_W'(enable_q);
            IRQ_THRESH:  bus_i.rdata = DATA_W'(thresh_q);
            IRQ_CLAIM:   bus_i.rdata = DATA_W'(claim_id);
            default: ;
        endcase
    end

    // A claim hands out an ID exactly when some source is eligible
    assert property (@(posedge clk_i) disable iff (!rst_n_i) (claim_id != '0) == (|eligible))
        else $error("claim ID disagrees with the eligible sources");

endmodule

`default_nettype wire

// File: logic/periph_pkg.sv
// ------------------------------------------------
// Peripheral subsystem definitions
// Bus widths, address map, register offsets and
// the two views of a bus word address
// ------------------------------------------------
`default_nettype none

package periph_pkg;

    // Bus geometry
    localparam int ADDR_W     = 12;
    localparam int DATA_W     = 32;
    localparam int PRIO_W     = 3;
    localparam int MAX_TIMERS = 8;
    localparam int IDX_W      = $clog2(MAX_TIMERS);
    // Claim IDs run from 0 (none) to MAX_TIMERS
    localparam int ID_W       = $clog2(MAX_TIMERS + 1);

    localparam logic [DATA_W-1:0] ERR_RDATA = 32'hdeadbeef;

    // ------------------------------------------------
    // Timer registers
    // ------------------------------------------------
    localparam logic [1:0] TMR_CTRL  = 2'd0;
    localparam logic [1:0] TMR_COUNT = 2'd1;
    localparam logic [1:0] TMR_CMP   = 2'd2;

    // Control word layout
    localparam int CTRL_EN_BIT = 0;
    localparam int PRESC_LSB   = 4;
    localparam int PRESC_W     = 4;

    // ------------------------------------------------
    // Interrupt controller registers
    // ------------------------------------------------
    localparam logic [2:0] IRQ_PRIO    = 3'd0;
    localparam logic [2:0] IRQ_PENDING = 3'd1;
    localparam logic [2:0] IRQ_ENABLE  = 3'd2;
    localparam logic [2:0] IRQ_THRESH  = 3'd3;
    localparam logic [2:0] IRQ_CLAIM   = 3'd4;

    typedef struct packed {
        logic             region;
        logic [IDX_W-1:0] unit;
        logic [5:0]       unused;
        logic [1:0]       offset;
    } timer_addr_t;

    typedef struct packed {
        logic             region;
        logic [2:0]       kind;
        logic [4:0]       unused;
        logic [IDX_W-1:0] src;
    } irq_addr_t;

    // Region bit 11 picks the view, 0 for timers
    typedef union packed {
        timer_addr_t tmr;
        irq_addr_t   irq;
    } bus_addr_u;

endpackage

`default_nettype wire

// File: logic/periph_reg_decoder.sv
// ------------------------------------------------
// Register bus decoder
// Routes each request to one timer or to the
// interrupt controller, flags unmapped addresses
// and returns a registered response
// ------------------------------------------------
`default_nettype none

module periph_reg_decoder
    import periph_pkg::*;
#(
    parameter int NUM_TIMERS = 4
) (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              req_i,
    input  logic              we_i,
    input  bus_addr_u         addr_i,
    input  logic [DATA_W-1:0] wdata_i,
    output logic              rsp_valid_o,
    output logic              err_o,
    output logic [DATA_W-1:0] rdata_o,
    periph_reg_if.decoder     tmr_o [NUM_TIMERS],
    periph_reg_if.decoder     irq_o
);

    logic                  region_irq;
    logic                  tmr_ok;
    logic                  irq_ok;
    logic                  map_err;
    logic [NUM_TIMERS-1:0] tmr_sel;
    logic                  irq_sel;
    logic [DATA_W-1:0]     tmr_rdata [NUM_TIMERS];
    logic [DATA_W-1:0]     rsp_rdata;
    logic                  rsp_valid_q;
    logic                  err_q;
    logic [DATA_W-1:0]     rdata_q;

    // Both views share the region bit
    assign region_irq = addr_i.irq.region;

    // ------------------------------------------------
    // Address check
    // ------------------------------------------------
    always_comb begin
        tmr_ok = !region_irq
                 && (int'(addr_i.tmr.unit) < NUM_TIMERS)
                 && (addr_i.tmr.offset <= TMR_CMP);
        irq_ok = region_irq
                 && (addr_i.irq.kind <= IRQ_CLAIM)
                 && ((addr_i.irq.kind != IRQ_PRIO) || (int'(addr_i.irq.src) < NUM_TIMERS));
    end

    assign map_err = req_i && !tmr_ok && !irq_ok;
    assign irq_sel = req_i && irq_ok;

    for (genvar i = 0; i < NUM_TIMERS; i++) begin : gen_tmr_bus
        assign tmr_sel[i]     = req_i && tmr_ok && (int'(addr_i.tmr.unit) == i);
        assign tmr_o[i].sel   = tmr_sel[i];
        assign tmr_o[i].we    = we_i;
        assign tmr_o[i].addr  = addr_i;
        assign tmr_o[i].wdata = wdata_i;
        assign tmr_rdata[i]   = tmr_o[i].rdata;
    end

    assign irq_o.sel   = irq_sel;
    assign irq_o.we    = we_i;
    assign irq_o.addr  = addr_i;
    assign irq_o.wdata = wdata_i;

    // ------------------------------------------------
    // Response path
    // ------------------------------------------------
    // Error pattern unless a client is selected
    always_comb begin
        rsp_rdata = ERR_RDATA;
        if (irq_sel) begin
            rsp_rdata = irq_o.rdata;
        end
        for (int i = 0; i < NUM_TIMERS; i++) begin
            if (tmr_sel[i]) begin
                rsp_rdata = tmr_rdata[i];
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rsp_valid_q <= 1'b0;
            err_q       <= 1'b0;
            rdata_q     <= '0;
        end else begin
            rsp_valid_q <= req_i;
            err_q       <= map_err;
            rdata_q     <= rsp_rdata;
        end
    end

    assign rsp_valid_o = rsp_valid_q;
    assign err_o       = err_q;
    assign rdata_o     = rdata_q;

    // Every request goes to exactly one client or to the error response
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        req_i |-> $onehot({map_err, irq_sel, tmr_sel}))
        else $error("decoder did not resolve the request to exactly one target");

endmodule

`default_nettype wire

// File: logic/periph_reg_if.sv
// ------------------------------------------------
// Register access link
// One decoded access from the decoder to a client
// ------------------------------------------------
`default_nettype none

interface periph_reg_if
    import periph_pkg::*;
();

    logic              sel;
    logic              we;
    bus_addr_u         addr;
    logic [DATA_W-1:0] wdata;
    // Driven combinationally by the client
    logic [DATA_W-1:0] rdata;

    modport decoder (
        output sel,
        output we,
        output addr,
        output wdata,
        input  rdata
    );

    modport client (
        input  sel,
        input  we,
        input  addr,
        input  wdata,
        output rdata
    );

endinterface

`default_nettype wire

// File: logic/periph_subsys.sv
// ------------------------------------------------
// Peripheral subsystem top level
// Register bus decoder, compare timers and the
// interrupt controller they feed
// ------------------------------------------------
`default_nettype none

module periph_subsys
    import periph_pkg::*;
#(
    parameter int NUM_TIMERS = 4
) (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              req_i,
    input  logic              we_i,
    input  logic [ADDR_W-1:0] addr_i,
    input  logic [DATA_W-1:0] wdata_i,
    output logic              rsp_valid_o,
    output logic [DATA_W-1:0] rdata_o,
    output logic              err_o,
    output logic              irq_o
);

    logic [NUM_TIMERS-1:0] expire;

    periph_reg_if tmr_bus [NUM_TIMERS] ();
    periph_reg_if irq_bus ();

    periph_reg_decoder #(
        .NUM_TIMERS ( NUM_TIMERS )
    ) i_decoder (
        .clk_i       ( clk_i       ),
        .rst_n_i     ( rst_n_i     ),
        .req_i       ( req_i       ),
        .we_i        ( we_i        ),
        .addr_i      ( addr_i      ),
        .wdata_i     ( wdata_i     ),
        .rsp_valid_o ( rsp_valid_o ),
        .err_o       ( err_o       ),
        .rdata_o     ( rdata_o     ),
        .tmr_o       ( tmr_bus     ),
        .irq_o       ( irq_bus     )
    );

    // Timer i raises interrupt ID i+1
    for (genvar i = 0; i < NUM_TIMERS; i++) begin : gen_timers
        periph_timer i_timer (
            .clk_i    ( clk_i      ),
            .rst_n_i  ( rst_n_i    ),
            .bus_i    ( tmr_bus[i] ),
            .expire_o ( expire[i]  )
        );
    end

    periph_irq_ctrl #(
        .NUM_TIMERS ( NUM_TIMERS )
    ) i_irq_ctrl (
        .clk_i    ( clk_i   ),
        .rst_n_i  ( rst_n_i ),
        .bus_i    ( irq_bus ),
        .expire_i ( expire  ),
        .irq_o    ( irq_o   )
    );

endmodule

`default_nettype wire

// File: logic/periph_timer.sv
// ------------------------------------------------
// Compare timer
// Prescaled up counter that wraps at the compare
// value and pulses expire for one cycle
// ------------------------------------------------
`default_nettype none

module periph_timer
    import periph_pkg::*;
(
    input  logic          clk_i,
    input  logic          rst_n_i,
    periph_reg_if.client  bus_i,
    output logic          expire_o
);

    logic               enable_q;
    logic [PRESC_W-1:0] presc_q;
    logic [PRESC_W-1:0] presc_cnt_q;
    logic [DATA_W-1:0]  count_q;
    logic [DATA_W-1:0]  cmp_q;
    logic               tick;
    logic               at_cmp;
    logic               wr_en;

    assign wr_en  = bus_i.sel && bus_i.we;
    assign tick   = enable_q && (presc_cnt_q >= presc_q);
    assign at_cmp = (count_q == cmp_q);

    // High in the cycle before count wraps to zero
    assign expire_o = tick && at_cmp;

    // ------------------------------------------------
    // Counters and registers
    // ------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            enable_q    <= 1'b0;
            presc_q     <= '0;
            presc_cnt_q <= '0;
            count_q     <= '0;
            cmp_q       <= '0;
        end else begin
            // Prescaler restarts from 0 on every enable
            if (!enable_q || tick) begin
                presc_cnt_q <= '0;
            end else begin
                presc_cnt_q <= presc_cnt_q + 1'b1;
            end

            if (tick) begin
                count_q <= at_cmp ? '0 : count_q + 1'b1;
            end

            // A software write to count overrides the tick
            if (wr_en) begin
                case (bus_i.addr.tmr.offset)
                    TMR_CTRL: begin
                        enable_q <= bus_i.wdata[CTRL_EN_BIT];
                        presc_q  <= bus_i.wdata[PRESC_LSB +: PRESC_W];
                    end
                    TMR_COUNT: count_q <= bus_i.wdata;
                    TMR_CMP:   cmp_q   <= bus_i.wdata;
                    default: ;
                endcase
            end
        end
    end

    // ------------------------------------------------
    // Read data
    // ------------------------------------------------
    always_comb begin
        bus_i.rdata = '0;
        case (bus_i.addr.tmr.offset)
            TMR_CTRL: begin
                bus_i.rdata[CTRL_EN_BIT]           = enable_q;
                bus_i.rdata[PRESC_LSB +: PRESC_W] = presc_q;
            end
            TMR_COUNT: bus_i.rdata = count_q;
            TMR_CMP:   bus_i.rdata = cmp_q;
            default: ;
        endcase
    end

    // Count restarts from zero after an expiry unless software loads it
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        expire_o && !(wr_en && (bus_i.addr.tmr.offset == TMR_COUNT)) |=> (count_q == '0))
        else $error("count did not wrap to zero after an expiry");

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the peripheral subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module periph_tb -o periph_tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/periph_tb_sim > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
    echo "Simulation failed"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi
echo "Simulation passed"
exit 0

// File: verif/periph_tb.sv
// ------------------------------------------------
// Peripheral subsystem testbench
// LFSR driven register traffic checked cycle by
// cycle against a register-level model
// ------------------------------------------------
`default_nettype none

module periph_tb
    import periph_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NT         = 4;
    localparam int N_READBACK = 40;
    localparam int N_UNMAPPED = 24;
    localparam int N_CONFIG   = 12;
    // Readback, unmapped plus sweep, timer runs, config changes, claims
    localparam int TEST_CYCLES = 2 * N_READBACK + N_UNMAPPED + 20 + NT * 96
                                 + 3 * N_CONFIG + 40;
    localparam int MAX_CYCLES  = TEST_CYCLES + 200;

    logic              clk;
    logic              rst_n;
    logic              req;
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic              rsp_valid;
    logic [DATA_W-1:0] rdata;
    logic              err;
    logic              irq;

    // Register-level model
    logic              m_en    [NT];
    logic [3:0]        m_presc [NT];
    logic [3:0]        m_pcnt  [NT];
    logic [DATA_W-1:0] m_count [NT];
    logic [DATA_W-1:0] m_cmp   [NT];
    logic [PRIO_W-1:0] m_prio  [NT];
    logic [NT-1:0]     m_enable;
    logic [NT-1:0]     m_pending;
    logic [PRIO_W-1:0] m_thresh;
    logic              m_irq;
    logic [15:0]       lfsr;
    int                cycles;

    periph_subsys #(
        .NUM_TIMERS ( NT )
    ) DUT (
        .clk_i       ( clk       ),
        .rst_n_i     ( rst_n     ),
        .req_i       ( req       ),
        .we_i        ( we        ),
        .addr_i      ( addr      ),
        .wdata_i     ( wdata     ),
        .rsp_valid_o ( rsp_valid ),
        .rdata_o     ( rdata     ),
        .err_o       ( err       ),
        .irq_o       ( irq       )
    );

    // ------------------------------------------------
    // Random numbers and addresses
    // ------------------------------------------------
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One LFSR step per bit taken
    function automatic logic [DATA_W-1:0] rand_bits(input int n);
        logic [DATA_W-1:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[DATA_W-2:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [ADDR_W-1:0] tmr_addr(input int unit, input logic [1:0] offset);
        bus_addr_u a;
        a            = '0;
        a.tmr.unit   = IDX_W'(unit);
        a.tmr.offset = offset;
        return a;
    endfunction

    function automatic logic [ADDR_W-1:0] irq_addr(input logic [2:0] kind, input int src);
        bus_addr_u a;
        a            = '0;
        a.irq.region = 1'b1;
        a.irq.kind   = kind;
        a.irq.src    = IDX_W'(src);
        return a;
    endfunction

    // ------------------------------------------------
    // Reference model
    // ------------------------------------------------
    function automatic logic is_eligible(input int i);
        return m_pending[i] && m_enable[i] && (m_prio[i] > m_thresh);
    endfunction

    // Upward scan with a strict compare keeps the lowest ID on a tie
    function automatic int best_id();
        int id;
        int best;
        id   = 0;
        best = -1;
        for (int i = 0; i < NT; i++) begin
            if (is_eligible(i) && (int'(m_prio[i]) > best)) begin
                id   = i + 1;
                best = int'(m_prio[i]);
            end
        end
        return id;
    endfunction

    task automatic expect_read(input bus_addr_u a, output logic [DATA_W-1:0] rd,
                               output logic e);
        int u;
        int s;
        u  = int'(a.tmr.unit);
        s  = int'(a.irq.src);
        rd = ERR_RDATA;
        e  = 1'b1;
        if (!a.tmr.region && (u < NT) && (a.tmr.offset != 2'd3)) begin
            e = 1'b0;
            case (a.tmr.offset)
                TMR_CTRL:  rd = {24'd0, m_presc[u], 3'd0, m_en[u]};
                TMR_COUNT: rd = m_count[u];
                default:   rd = m_cmp[u];
            endcase
        end else if (a.irq.region && (a.irq.kind <= IRQ_CLAIM)
                     && ((a.irq.kind != IRQ_PRIO) || (s < NT))) begin
            e = 1'b0;
            case (a.irq.kind)
                IRQ_PRIO:    rd = DATA_W'(m_prio[s]);
                IRQ_PENDING: rd = DATA_W'(m_pending);
                IRQ_ENABLE:  rd = DATA_W'(m_enable);
                IRQ_THRESH:  rd = DATA_W'(m_thresh);
                default:     rd = DATA_W'(best_id());
            endcase
        end
    endtask

    // Mirrors one rising edge using the inputs driven before it
    task automatic model_edge();
        bus_addr_u     a;
        logic [NT-1:0] expired;
        logic          tick;
        int            id;
        int            u;
        int            s;
        a       = addr;
        u       = int'(a.tmr.unit);
        s       = int'(a.irq.src);
        expired = '0;
        id      = best_id();
        m_irq   = (id != 0);
        for (int t = 0; t < NT; t++) begin
            tick       = m_en[t] && (m_pcnt[t] >= m_presc[t]);
            expired[t] = tick && (m_count[t] == m_cmp[t]);
            m_pcnt[t]  = (!m_en[t] || tick) ? 4'd0 : m_pcnt[t] + 4'd1;
            if (tick) begin
                m_count[t] = expired[t] ? '0 : m_count[t] + 32'd1;
            end
        end
        if (req && !we && a.irq.region && (a.irq.kind == IRQ_CLAIM) && (id != 0)) begin
            m_pending[id-1] = 1'b0;
        end
        m_pending = m_pending | expired;
        if (req && we && !a.tmr.region && (u < NT)) begin
            case (a.tmr.offset)
                TMR_CTRL: begin
                    m_en[u]    = wdata[0];
                    m_presc[u] = wdata[7:4];
                end
                TMR_COUNT: m_count[u] = wdata;
                TMR_CMP:   m_cmp[u]   = wdata;
                default: ;
            endcase
        end
        if (req && we && a.irq.region) begin
            case (a.irq.kind)
                IRQ_PRIO: begin
                    if (s < NT) begin
                        m_prio[s] = wdata[PRIO_W-1:0];
                    end
                end
                IRQ_ENABLE: m_enable = wdata[NT-1:0];
                IRQ_THRESH: m_thresh = wdata[PRIO_W-1:0];
                default: ;
            endcase
        end
    endtask

    // ------------------------------------------------
    // Checks
    // ------------------------------------------------
    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_rdata(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                               input string what);
        if (got !== exp) begin
            stop_on_error($sformatf("mismatch at %0d ns: %s is %h, expected %h",
                                    $time, what, got, exp));
        end
    endtask

    task automatic check_err(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            stop_on_error($sformatf("mismatch at %0d ns: %s is %b, expected %b",
                                    $time, what, got, exp));
        end
    endtask

    task automatic check_irq(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            stop_on_error($sformatf("mismatch at %0d ns: %s is %b, expected %b",
                                    $time, what, got, exp));
        end
    endtask

    // ------------------------------------------------
    // Bus driving
    // ------------------------------------------------
    task automatic step_cycle();
        @(posedge clk);
        model_edge();
        #1;
        check_irq(irq, m_irq, "irq_o");
    endtask

    // A cycle without a request must not produce a response
    task automatic idle_cycle();
        step_cycle();
        if (rsp_valid !== 1'b0) begin
            stop_on_error("a response appeared in a cycle without a request");
        end
    endtask

    task automatic bus_access(input logic w, input logic [ADDR_W-1:0] a,
                              input logic [DATA_W-1:0] d, output logic [DATA_W-1:0] got);
        logic [DATA_W-1:0] exp_rd;
        logic              exp_err;
        expect_read(a, exp_rd, exp_err);
        req   = 1'b1;
        we    = w;
        addr  = a;
        wdata = d;
        step_cycle();
        req = 1'b0;
        we  = 1'b0;
        if (rsp_valid !== 1'b1) begin
            stop_on_error($sformatf("no response in the cycle after the request to %h", a));
        end
        check_err(err, exp_err, $sformatf("err_o for address %h", a));
        check_rdata(rdata, exp_rd, $sformatf("rdata_o for address %h", a));
        got = rdata;
    endtask

    task automatic read_all_regs();
        logic [DATA_W-1:0] got;
        for (int u = 0; u < NT; u++) begin
            for (int o = 0; o < 3; o++) begin
                bus_access(1'b0, tmr_addr(u, 2'(o)), '0, got);
            end
            bus_access(1'b0, irq_addr(IRQ_PRIO, u), '0, got);
        end
        bus_access(1'b0, irq_addr(IRQ_ENABLE, 0), '0, got);
        bus_access(1'b0, irq_addr(IRQ_THRESH, 0), '0, got);
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            stop_on_error($sformatf("simulation timed out after %0d cycles", cycles));
        end
    end

    // ------------------------------------------------
    // Test sequence
    // ------------------------------------------------
    initial begin
        logic [DATA_W-1:0] got;
        logic [DATA_W-1:0] data;
        logic [DATA_W-1:0] exp_rd;
        logic [ADDR_W-1:0] a;
        logic [2:0]        pick;
        logic              exp_err;
        int                limit;
        int                waited;
        rst_n     = 1'b0;
        req       = 1'b0;
        we        = 1'b0;
        addr      = '0;
        wdata     = '0;
        lfsr      = 16'd87;
        m_enable  = '0;
        m_pending = '0;
        m_thresh  = '0;
        m_irq     = 1'b0;
        for (int t = 0; t < NT; t++) begin
            m_en[t]    = 1'b0;
            m_presc[t] = '0;
            m_pcnt[t]  = '0;
            m_count[t] = '0;
            m_cmp[t]   = '0;
            m_prio[t]  = '0;
        end
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_irq(irq, 1'b0, "irq_o after reset");
        if ((rsp_valid !== 1'b0) || (err !== 1'b0)) begin
            stop_on_error("response outputs are not idle after reset");
        end

        // Readback with every timer kept disabled
        for (int i = 0; i < N_READBACK; i++) begin
            pick = 3'(rand_bits(3));
            data = rand_bits(32);
            if (pick < 3'd4) begin
                a = tmr_addr(int'(rand_bits(2)), 2'(pick % 3'd3));
                if (a[1:0] == TMR_CTRL) begin
                    data[CTRL_EN_BIT] = 1'b0;
                end
            end else if (pick == 3'd4) begin
                a = irq_addr(IRQ_ENABLE, 0);
            end else if (pick == 3'd5) begin
                a = irq_addr(IRQ_THRESH, 0);
            end else begin
                a = irq_addr(IRQ_PRIO, int'(rand_bits(2)));
            end
            bus_access(1'b1, a, data, got);
            bus_access(1'b0, a, '0, got);
        end

        // Unmapped accesses, then a sweep over every mapped register
        for (int i = 0; i < N_UNMAPPED; i++) begin
            exp_err = 1'b0;
            while (!exp_err) begin
                a = ADDR_W'(rand_bits(ADDR_W));
                expect_read(a, exp_rd, exp_err);
            end
            bus_access(1'(rand_bits(1)), a, rand_bits(32), got);
        end
        read_all_regs();

        // Timer expiry with every source eligible
        bus_access(1'b1, irq_addr(IRQ_THRESH, 0), '0, got);
        bus_access(1'b1, irq_addr(IRQ_ENABLE, 0), DATA_W'((1 << NT) - 1), got);
        for (int t = 0; t < NT; t++) begin
            bus_access(1'b1, irq_addr(IRQ_PRIO, t), rand_bits(2) + 32'd1, got);
        end
        for (int t = 0; t < NT; t++) begin
            data  = rand_bits(3);
            pick  = 3'(rand_bits(2));
            limit = (int'(data) + 1) * (int'(pick) + 1) + 8;
            bus_access(1'b1, tmr_addr(t, TMR_COUNT), '0, got);
            bus_access(1'b1, tmr_addr(t, TMR_CMP), data, got);
            bus_access(1'b1, tmr_addr(t, TMR_CTRL), {24'd0, 1'b0, pick, 3'd0, 1'b1}, got);
            waited = 0;
            got    = '0;
            while (!got[t]) begin
                if (2 * waited > limit) begin
                    stop_on_error($sformatf("pending bit of timer %0d was never set", t));
                end
                bus_access(1'b0, tmr_addr(t, TMR_COUNT), '0, got);
                bus_access(1'b0, irq_addr(IRQ_PENDING, 0), '0, got);
                waited = waited + 1;
            end
            bus_access(1'b1, tmr_addr(t, TMR_CTRL), '0, got);
        end

        // irq_o against threshold, enable and priority changes
        for (int i = 0; i < N_CONFIG; i++) begin
            pick = 3'(rand_bits(2));
            if (pick == 3'd0) begin
                a = irq_addr(IRQ_THRESH, 0);
            end else if (pick == 3'd1) begin
                a = irq_addr(IRQ_ENABLE, 0);
            end else begin
                a = irq_addr(IRQ_PRIO, int'(rand_bits(2)));
            end
            bus_access(1'b1, a, rand_bits(8), got);
            idle_cycle();
            idle_cycle();
        end

        // Claims drain the pending sources in priority order
        bus_access(1'b1, irq_addr(IRQ_THRESH, 0), '0, got);
        bus_access(1'b1, irq_addr(IRQ_ENABLE, 0), DATA_W'((1 << NT) - 1), got);
        for (int t = 0; t < NT; t++) begin
            bus_access(1'b1, irq_addr(IRQ_PRIO, t), rand_bits(2) + 32'd1, got);
        end
        for (int i = 0; i <= NT; i++) begin
            bus_access(1'b0, irq_addr(IRQ_CLAIM, 0), '0, got);
            bus_access(1'b0, irq_addr(IRQ_PENDING, 0), '0, data);
        end
        check_rdata(got, '0, "claim ID once all sources are served");
        check_rdata(data, '0, "pending bits after the claims");
        idle_cycle();
        idle_cycle();
        check_irq(irq, 1'b0, "irq_o after the last claim");

        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire
